// File: Bender.yml
package:
  name: alu_unit

sources:
  - files:
      - hw/alu_pkg.sv
      - hw/alu_core.sv
      - hw/alu_flags.sv
      - hw/alu_regs.sv
      - hw/alu_unit.sv
  - target: simulation
    files:
      - sim/alu_unit_checker.sv
      - sim/alu_unit_tb.sv

// File: alu_unit.f
hw/alu_pkg.sv
hw/alu_core.sv
hw/alu_flags.sv
hw/alu_regs.sv
hw/alu_unit.sv
sim/alu_unit_checker.sv
sim/alu_unit_tb.sv

// File: hw/alu_core.sv
module alu_core (
    input  alu_pkg::alu_cmd_t cmd,
    input  alu_pkg::flag_t    flags,
    output alu_pkg::alu_rsp_t rsp
);
    import alu_pkg::*;

    logic        is_sub;
    logic [31:0] add_b;
    logic [31:0] sum;
    logic        carry;

    logic [31:0] shl_res;
    logic [31:0] shr_res;
    logic [31:0] ldhi_res;
    logic [31:0] ldlo_res;

    logic        a_eq_b;
    logic        a_lt_b;
    logic        a_gt_b;
    logic        take_branch;

    assign is_sub = (cmd.op == op_sub);

    // Ripple adder, subtract by inverting b with carry in set
    always_comb
    begin
        add_b = is_sub ? ~cmd.b : cmd.b;
        carry = is_sub;
        for (int i = 0; i < 32; i++)
        begin
            sum[i] = cmd.a[i] ^ add_b[i] ^ carry;
            carry  = (cmd.a[i] & add_b[i]) | (cmd.a[i] & carry) | (add_b[i] & carry);
        end
    end

    // Ones fill by shifting the inverted operand
    assign shl_res = ~((~cmd.a) << cmd.b[4:0]);
    assign shr_res = ~((~cmd.a) >> cmd.b[4:0]);

    // Half-word immediate merge
    assign ldhi_res = {cmd.imm, cmd.a[15:0]};
    assign ldlo_res = {cmd.a[31:16], cmd.imm};

    assign a_eq_b = (cmd.a == cmd.b);
    assign a_lt_b = (cmd.a < cmd.b);  // Unsigned
    assign a_gt_b = (cmd.a > cmd.b);

    always_comb
    begin
        case (cmd.op)
            op_jmp:   take_branch = 1'b1;
            op_jcond: take_branch = flags.cond;
            default:  take_branch = 1'b0;
        endcase
    end

    always_comb
    begin
        rsp.result    = '0;
        rsp.cmp_valid = 1'b0;
        rsp.cmp_true  = 1'b0;
        case (cmd.op)
            op_add, op_sub:   rsp.result = sum;
            op_shl:           rsp.result = shl_res;
            op_shr:           rsp.result = shr_res;
            op_pass, op_pass2: rsp.result = cmd.a;
            op_ldhi:          rsp.result = ldhi_res;
            op_ldlo:          rsp.result = ldlo_res;
            op_cmp_eq:
            begin
                rsp.cmp_valid = 1'b1;
                rsp.cmp_true  = a_eq_b;
            end
            op_cmp_lt:
            begin
                rsp.cmp_valid = 1'b1;
                rsp.cmp_true  = a_lt_b;
            end
            op_cmp_gt:
            begin
                rsp.cmp_valid = 1'b1;
                rsp.cmp_true  = a_gt_b;
            end
            default:          rsp.result = '0;  // Flag and branch ops
        endcase
    end

    assign rsp.jump  = take_branch;
    assign rsp.naddr = take_branch ? cmd.base : '0;

    // Register block always presents a defined opcode once out of reset
    always_comb
    begin
        assert final (!$isunknown(cmd.op))
        else $error("alu_core: opcode is unknown");
    end

endmodule

// File: hw/alu_flags.sv
module alu_flags (
    input  logic             clock,
    input  logic             arst_n,
    input  logic             exec,
    input  alu_pkg::alu_op_e op,
    input  logic             cmp_valid,
    input  logic             cmp_true,
    input  logic             aux_we,
    input  logic             aux_in,
    output alu_pkg::flag_t   flags
);
    import alu_pkg::*;

    logic cond_q;
    logic aux_q;

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cond_q <= 1'b0;
            aux_q  <= 1'b0;
        end
        else if (exec)
        begin
            if (cmp_valid)
            begin
                cond_q <= cmp_true;
            end
            else
            begin
                case (op)
                    op_not, op_not2: cond_q <= ~cond_q;
                    op_and:          cond_q <= cond_q & aux_q;  // Uses aux before this write
                    default:         cond_q <= cond_q;
                endcase
            end
            if (aux_we)
            begin
                aux_q <= aux_in;
            end
        end
    end

    assign flags.cond = cond_q;
    assign flags.aux  = aux_q;

    // Core reports a compare outcome only for a compare opcode from the register block
    assert property (@(posedge clock) disable iff (!arst_n)
        cmp_valid |-> (op inside {op_cmp_eq, op_cmp_lt, op_cmp_gt}))
    else $error("alu_flags: compare outcome on a non-compare opcode");

endmodule

// File: hw/alu_pkg.sv
package alu_pkg;

    // ALU opcodes, as held in CMD bits 3:0
    typedef enum logic [3:0] {
        op_add    = 4'd0,
        op_sub    = 4'd1,
        op_shl    = 4'd2,  // Ones fill from the right
        op_shr    = 4'd3,  // Ones fill from the left
        op_pass   = 4'd4,
        op_ldhi   = 4'd5,
        op_ldlo   = 4'd6,
        op_pass2  = 4'd7,
        op_cmp_eq = 4'd8,
        op_cmp_lt = 4'd9,
        op_cmp_gt = 4'd10,
        op_not    = 4'd11,
        op_and    = 4'd12,
        op_not2   = 4'd13,
        op_jmp    = 4'd14,
        op_jcond  = 4'd15
    } alu_op_e;

    // One command as seen by the core
    typedef struct packed {
        alu_op_e     op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] base;  // Branch target
        logic [15:0] imm;
    } alu_cmd_t;

    typedef struct packed {
        logic [31:0] result;
        logic        cmp_valid;
        logic        cmp_true;
        logic        jump;
        logic [31:0] naddr;
    } alu_rsp_t;

    typedef struct packed {
        logic cond;
        logic aux;
    } flag_t;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [4:0]  adr;  // Byte offset
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // Register map
    localparam logic [4:0] REG_A      = 5'h00;
    localparam logic [4:0] REG_B      = 5'h04;
    localparam logic [4:0] REG_BASE   = 5'h08;
    localparam logic [4:0] REG_CMD    = 5'h0C;  // Write starts the operation
    localparam logic [4:0] REG_RESULT = 5'h10;
    localparam logic [4:0] REG_STATUS = 5'h14;  // {jump, aux, cond}
    localparam logic [4:0] REG_NADDR  = 5'h18;

endpackage

// File: hw/alu_regs.sv
module alu_regs (
    input  logic              clock,
    input  logic              arst_n,
    input  alu_pkg::wb_req_t  wb_req,
    output alu_pkg::wb_rsp_t  wb_rsp,
    output alu_pkg::alu_cmd_t cmd,
    output logic              exec,
    output logic              aux_we,
    output logic              aux_in,
    input  alu_pkg::alu_rsp_t rsp,
    input  alu_pkg::flag_t    flags
);
    import alu_pkg::*;

    logic [31:0] a_q;
    logic [31:0] b_q;
    logic [31:0] base_q;
    logic [31:0] cmd_q;
    logic [31:0] result_q;
    logic [31:0] naddr_q;
    logic        jump_q;
    logic        ack_q;
    logic        exec_q;
    logic [31:0] rdat_q;
    logic [31:0] rdat;
    logic        access;
    logic        wr;
    logic        updates_result;

    function automatic logic [31:0] byte_merge(
        input logic [31:0] old_val,
        input logic [31:0] wdat,
        input logic [3:0]  sel
    );
        logic [31:0] merged;
        merged = old_val;
        for (int i = 0; i < 4; i++)
        begin
            if (sel[i])
            begin
                merged[8*i +: 8] = wdat[8*i +: 8];
            end
        end
        return merged;
    endfunction

    // New transfer seen, ack goes out next cycle
    assign access = wb_req.cyc & wb_req.stb & ~ack_q;
    assign wr     = access & wb_req.we;

    // Compare and flag ops leave RESULT, STATUS jump and NADDR alone
    assign updates_result = !(cmd.op inside {[op_cmp_eq:op_not2]});

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ack_q  <= 1'b0;
            exec_q <= 1'b0;
        end
        else
        begin
            ack_q  <= access;
            exec_q <= wr && (wb_req.adr == REG_CMD);
        end
    end

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            a_q    <= '0;
            b_q    <= '0;
            base_q <= '0;
            cmd_q  <= '0;
        end
        else if (wr)
        begin
            case (wb_req.adr)
                REG_A:    a_q    <= byte_merge(a_q, wb_req.dat, wb_req.sel);
                REG_B:    b_q    <= byte_merge(b_q, wb_req.dat, wb_req.sel);
                REG_BASE: base_q <= byte_merge(base_q, wb_req.dat, wb_req.sel);
                REG_CMD:  cmd_q  <= wb_req.dat;  // Whole word
                default:  ;
            endcase
        end
    end

    // Capture at the edge that ends the CMD cycle
    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            result_q <= '0;
            jump_q   <= 1'b0;
            naddr_q  <= '0;
        end
        else if (exec_q && updates_result)
        begin
            result_q <= rsp.result;
            jump_q   <= rsp.jump;
            if (rsp.jump)
            begin
                naddr_q <= rsp.naddr;
            end
        end
    end

    always_comb
    begin
        case (wb_req.adr)
            REG_A:      rdat = a_q;
            REG_B:      rdat = b_q;
            REG_BASE:   rdat = base_q;
            REG_CMD:    rdat = cmd_q;
            REG_RESULT: rdat = result_q;
            REG_STATUS: rdat = {29'd0, jump_q, flags.aux, flags.cond};
            REG_NADDR:  rdat = naddr_q;
            default:    rdat = '0;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (access && !wb_req.we)
        begin
            rdat_q <= rdat;
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rdat_q;

    assign cmd.op   = alu_op_e'(cmd_q[3:0]);
    assign cmd.a    = a_q;
    assign cmd.b    = b_q;
    assign cmd.base = base_q;
    assign cmd.imm  = cmd_q[31:16];

    assign exec   = exec_q;
    assign aux_we = cmd_q[8];
    assign aux_in = cmd_q[9];

    // Master holds its request through the ack cycle
    assert property (@(posedge clock) disable iff (!arst_n)
        ack_q |-> (wb_req.cyc && wb_req.stb))
    else $error("alu_regs: ack without a held request");

    // Exec only in the ack cycle of a CMD write
    assert property (@(posedge clock) disable iff (!arst_n)
        exec_q |-> (ack_q && wb_req.we && (wb_req.adr == REG_CMD)))
    else $error("alu_regs: exec without an acked CMD write");

endmodule

// File: hw/alu_unit.sv
module alu_unit (
    input  logic             clock,
    input  logic             arst_n,
    input  alu_pkg::wb_req_t wb_req,
    output alu_pkg::wb_rsp_t wb_rsp
);
    import alu_pkg::*;

    alu_cmd_t cmd;
    alu_rsp_t rsp;
    flag_t    flags;
    logic     exec;
    logic     aux_we;
    logic     aux_in;

    alu_regs regs0 (
        .clock  (clock),
        .arst_n (arst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .cmd    (cmd),
        .exec   (exec),
        .aux_we (aux_we),
        .aux_in (aux_in),
        .rsp    (rsp),
        .flags  (flags)
    );

    alu_core core0 (
        .cmd   (cmd),
        .flags (flags),
        .rsp   (rsp)
    );

    alu_flags flags0 (
        .clock     (clock),
        .arst_n    (arst_n),
        .exec      (exec),
        .op        (cmd.op),
        .cmp_valid (rsp.cmp_valid),
        .cmp_true  (rsp.cmp_true),
        .aux_we    (aux_we),
        .aux_in    (aux_in),
        .flags     (flags)
    );

endmodule

// File: sim/alu_unit_checker.sv
module alu_unit_checker (
    input logic             clock,
    input alu_pkg::wb_req_t wb_req,
    input alu_pkg::wb_rsp_t wb_rsp
);
    timeunit 1ns;
    timeprecision 100ps;

    import alu_pkg::*;

    int tests_run   = 0;
    int tests_bad   = 0;
    int bus_errors  = 0;
    int wait_cycles = 0;

    // Reference model state
    logic [31:0] m_result = '0;
    logic [31:0] m_naddr  = '0;
    logic        m_jump   = 1'b0;
    logic        m_cond   = 1'b0;
    logic        m_aux    = 1'b0;

    // Ack must come exactly one cycle after a new request
    always @(negedge clock)
    begin
        if (wb_req.cyc && wb_req.stb)
        begin
            if (wb_rsp.ack)
            begin
                if (wait_cycles != 1)
                begin
                    $display("Bus ack came %0d cycles after the request instead of 1",
                             wait_cycles);
                    bus_errors++;
                end
                wait_cycles = 0;
            end
            else
            begin
                wait_cycles++;
            end
        end
    end

    task automatic check_reset(input logic [31:0] vals [7]);
        int bad;
        bad = 0;
        tests_run++;
        for (int i = 0; i < 7; i++)
        begin
            if (vals[i] !== 32'd0)
            begin
                $display("ERR %0t: reset register at offset %0h reads %h", $time, 4 * i,
                         vals[i]);
                bad++;
            end
        end
        if (bad != 0)
            tests_bad++;
        $display("test %0d reset values: %s", tests_run, (bad == 0) ? "ok" : "failed");
    endtask

    task automatic check_op(
        input logic [3:0]  op,
        input logic        aux_we,
        input logic        aux_v,
        input logic [31:0] a_full,
        input logic [31:0] b,
        input logic [31:0] base,
        input logic [15:0] imm,
        input logic [3:0]  psel,
        input logic [31:0] pa,
        input logic [31:0] got_result,
        input logic [31:0] got_status,
        input logic [31:0] got_naddr
    );
        logic [31:0] a;
        logic [31:0] v;
        logic [31:0] exp_status;
        alu_op_e     op_e;
        int          bad;
        bad = 0;
        tests_run++;
        op_e = alu_op_e'(op);
        a = a_full;
        for (int i = 0; i < 4; i++)
            if (psel[i])
                a[8*i +: 8] = pa[8*i +: 8];  // Partial write lands on selected bytes
        case (op)
            4'd0: v = a + b;
            4'd1: v = a - b;
            4'd2:
            begin
                v = a;
                repeat (b[4:0]) v = {v[30:0], 1'b1};
            end
            4'd3:
            begin
                v = a;
                repeat (b[4:0]) v = {1'b1, v[31:1]};
            end
            4'd5: v = {imm, a[15:0]};
            4'd6: v = {a[31:16], imm};
            default: v = a;  // pass and pass2
        endcase
        case (op)
            4'd8: m_cond = (a == b);
            4'd9: m_cond = (a < b);
            4'd10: m_cond = (a > b);
            4'd11, 4'd13: m_cond = ~m_cond;
            4'd12: m_cond = m_cond & m_aux;
            4'd14:
            begin
                m_result = '0;  // Branches write a zero result
                m_jump   = 1'b1;
                m_naddr  = base;
            end
            4'd15:
            begin
                m_result = '0;
                m_jump   = m_cond;
                if (m_cond)
                    m_naddr = base;
            end
            default:
            begin
                m_result = v;
                m_jump   = 1'b0;
            end
        endcase
        if (aux_we)
            m_aux = aux_v;
        exp_status = {29'd0, m_jump, m_aux, m_cond};
        if (got_result !== m_result)
        begin
            $display("ERR %0t: RESULT got %h expected %h", $time, got_result, m_result);
            bad++;
        end
        if (got_status !== exp_status)
        begin
            $display("ERR %0t: STATUS got %h expected %h", $time, got_status, exp_status);
            bad++;
        end
        if (got_naddr !== m_naddr)
        begin
            $display("ERR %0t: NADDR got %h expected %h", $time, got_naddr, m_naddr);
            bad++;
        end
        if (bad != 0)
            tests_bad++;
        $display("test %0d %s a=%h b=%h: %s", tests_run, op_e.name(), a, b,
                 (bad == 0) ? "ok" : "failed");
    endtask

endmodule

// File: sim/alu_unit_tb.sv
module alu_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import alu_pkg::*;

    typedef struct packed {
        logic [3:0]  op;
        logic        aux_we;
        logic        aux_v;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] base;
        logic [15:0] imm;
        logic [3:0]  psel;  // Second, partial write to A when nonzero
        logic [31:0] pa;
    } entry_t;

    logic        clock;
    logic        arst_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic [31:0] lfsr_q = 32'd94119;
    entry_t      table_q[$];

    alu_unit dut0 (
        .clock  (clock),
        .arst_n (arst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    alu_unit_checker chk0 (
        .clock  (clock),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial
    begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_step()};
        return v;
    endfunction

    task automatic wait_for_ack(output logic [31:0] rdat);
        int cycles;
        cycles = 0;
        do
        begin
            @(negedge clock);
            cycles++;
            if (cycles > 20)
            begin
                $display("Bus timeout: no ack within 20 cycles at offset %h", wb_req.adr);
                $display("TEST RESULT: FAIL");
                $finish;
            end
        end
        while (!wb_rsp.ack);
        rdat = wb_rsp.dat;
        @(posedge clock);
        wb_req <= '0;
    endtask

    task automatic bus_write(input logic [4:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel);
        logic [31:0] unused;
        @(posedge clock);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat, sel: sel};
        wait_for_ack(unused);
    endtask

    task automatic bus_read(input logic [4:0] adr, output logic [31:0] dat);
        @(posedge clock);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'd0, sel: 4'd0};
        wait_for_ack(dat);
    endtask

    task automatic add_entry(input logic [3:0] op, input logic aux_we, input logic aux_v,
                             input logic [31:0] a, input logic [31:0] b,
                             input logic [31:0] base, input logic [15:0] imm);
        table_q.push_back('{op, aux_we, aux_v, a, b, base, imm, 4'd0, 32'd0});
    endtask

    initial
    begin
        logic [31:0] rv [7];
        logic [31:0] result;
        logic [31:0] status;
        logic [31:0] naddr;
        entry_t      e;

        wb_req = '0;
        arst_n = 1'b0;
        repeat (4) @(posedge clock);
        arst_n <= 1'b1;

        for (int i = 0; i < 7; i++)
            bus_read(5'(4 * i), rv[i]);
        chk0.check_reset(rv);

        add_entry(4'd0, 0, 0, 32'hFFFF_FFFF, 32'd1, 0, 0);  // Overflow
        add_entry(4'd1, 0, 0, 32'd0, 32'd1, 0, 0);
        add_entry(4'd0, 0, 0, 32'h7FFF_FFFF, 32'd1, 0, 0);
        add_entry(4'd4, 0, 0, 32'h1234_5678, 32'd9, 0, 0);
        add_entry(4'd7, 0, 0, 32'hDEAD_BEEF, 32'd0, 0, 0);
        add_entry(4'd2, 0, 0, 32'h0000_0000, 32'd0, 0, 0);
        add_entry(4'd2, 0, 0, 32'h0000_0010, 32'd1, 0, 0);
        add_entry(4'd2, 0, 0, 32'h0000_0001, 32'd31, 0, 0);
        add_entry(4'd3, 0, 0, 32'h8000_0000, 32'd1, 0, 0);
        add_entry(4'd3, 0, 0, 32'h0000_0000, 32'd31, 0, 0);
        add_entry(4'd5, 0, 0, 32'h5555_1111, 32'd0, 0, 16'hABCD);
        add_entry(4'd6, 0, 0, 32'h5555_1111, 32'd0, 0, 16'h1234);
        add_entry(4'd8, 0, 0, 32'd7, 32'd7, 0, 0);
        add_entry(4'd11, 1, 1, 32'd0, 32'd0, 0, 0);
        add_entry(4'd13, 0, 0, 32'd0, 32'd0, 0, 0);
        add_entry(4'd12, 0, 0, 32'd0, 32'd0, 0, 0);
        add_entry(4'd15, 0, 0, 32'd0, 32'd0, 32'h100, 0);
        add_entry(4'd9, 0, 0, 32'd5, 32'd3, 0, 0);
        add_entry(4'd15, 0, 0, 32'd0, 32'd0, 32'h200, 0);  // Not taken
        add_entry(4'd14, 0, 0, 32'd0, 32'd0, 32'h300, 0);
        add_entry(4'd10, 1, 0, 32'd9, 32'd3, 0, 0);
        add_entry(4'd12, 0, 0, 32'd0, 32'd0, 0, 0);
        table_q.push_back('{4'd4, 1'b0, 1'b0, 32'h1122_3344, 32'd0, 32'd0, 16'd0,
                            4'b0101, 32'hAABB_CCDD});
        for (int i = 0; i < 12; i++)
        begin
            e.op     = 4'(random_bits(4));
            e.aux_we = 1'(random_bits(1));
            e.aux_v  = 1'(random_bits(1));
            e.a      = random_bits(32);
            e.b      = random_bits(32);
            e.base   = random_bits(32);
            e.imm    = 16'(random_bits(16));
            e.psel   = 4'd0;
            e.pa     = 32'd0;
            table_q.push_back(e);
        end

        foreach (table_q[i])
        begin
            e = table_q[i];
            bus_write(REG_A, e.a, 4'hF);
            if (e.psel != 4'd0)
                bus_write(REG_A, e.pa, e.psel);
            bus_write(REG_B, e.b, 4'hF);
            bus_write(REG_BASE, e.base, 4'hF);
            bus_write(REG_CMD, {e.imm, 6'd0, e.aux_v, e.aux_we, 4'd0, e.op}, 4'hF);
            bus_read(REG_RESULT, result);
            bus_read(REG_STATUS, status);
            bus_read(REG_NADDR, naddr);
            chk0.check_op(e.op, e.aux_we, e.aux_v, e.a, e.b, e.base, e.imm, e.psel, e.pa,
                          result, status, naddr);
        end

        repeat (2) @(posedge clock);
        $display("tests %0d, failed %0d, bus errors %0d", chk0.tests_run, chk0.tests_bad,
                 chk0.bus_errors);
        if (chk0.tests_bad == 0 && chk0.bus_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
